/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_poc_scan
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
hw/poc_pkg.sv
hw/step_if.sv
hw/pd_sampler.sv
hw/tap_scan.sv
hw/phase_stepper.sv
hw/edge_tracker.sv
hw/poc_scan_top.sv
verif/poc_scan_assert.sv
verif/tb_poc_scan.sv

/* hw/edge_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module edge_tracker (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        run_end,
  input  wire  [poc_pkg::TAP_W-1:0]  run,
  input  wire                        run_polarity,
  input  wire  [poc_pkg::TAP_W-1:0]  tap,
  output logic [poc_pkg::TAP_W-1:0]  last_run,
  output logic                       run_too_small,
  output logic [poc_pkg::TAP_W-1:0]  rise_tap,
  output logic [poc_pkg::TAP_W-1:0]  fall_tap,
  output logic [poc_pkg::EDGE_W-1:0] edges_seen
);

  logic short_run;
  logic edges_full;

  assign short_run = (run < poc_pkg::SHORT_RUN_LEN);
  assign edges_full = &edges_seen;

  always_ff @(posedge clk) begin
    if (rst) begin
      last_run      <= '0;
      run_too_small <= 1'b0;
      rise_tap      <= '0;
      fall_tap      <= '0;
      edges_seen    <= '0;
    end else if (run_end) begin
      last_run      <= run;
      run_too_small <= short_run;

      // Polarity is still the old one during run_end.
      if (!run_polarity) begin
        rise_tap <= tap;
      end else begin
        fall_tap <= tap;
      end

      if (!edges_full) begin
        edges_seen <= edges_seen + poc_pkg::EDGE_ONE;  // Saturates.
      end
    end
  end

endmodule

`default_nettype wire

/* hw/pd_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module pd_sampler (
  input  wire  clk,
  input  wire  rst,
  input  wire  pd_out,
  input  wire  sample_en,
  input  wire  settle_start,
  input  wire  window_done,
  output logic sample_strobe,
  output logic sample_value
);

  logic                         pd_r;
  logic                         armed;
  logic [poc_pkg::SETTLE_W-1:0] settle_cnt;
  logic                         settle_last;

  // Detector registered once.
  always_ff @(posedge clk) begin
    pd_r <= pd_out;
  end

  assign sample_value = pd_r;
  assign settle_last = (settle_cnt == poc_pkg::SETTLE_ONE) && !settle_start;

  always_ff @(posedge clk) begin
    if (rst) begin
      settle_cnt    <= poc_pkg::SETTLE_LOAD;
      armed         <= 1'b0;
      sample_strobe <= 1'b0;
    end else begin
      sample_strobe <= armed && sample_en;

      // Clock is still moving until the count runs out.
      if (settle_start) begin
        settle_cnt <= poc_pkg::SETTLE_LOAD;
      end else if (|settle_cnt) begin
        settle_cnt <= settle_cnt - poc_pkg::SETTLE_ONE;
      end

      if (window_done) begin
        armed <= 1'b0;
      end else if (settle_last) begin
        armed <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/phase_stepper.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_stepper (
  input  wire      clk,
  input  wire      rst,
  input  wire      psdone,
  step_if.stepper  step,
  output logic     psen,
  output logic     done
);

  logic [poc_pkg::TAP_W-1:0] tap_r;
  logic [poc_pkg::TAP_W-1:0] tap_next;
  logic                      busy_r;

  assign step.tap  = tap_r;
  assign step.busy = busy_r;
  assign step.done = done;

  // Wraps at taps per fabric clock.
  assign tap_next = (tap_r == poc_pkg::TAP_LAST) ? '0 : tap_r + poc_pkg::TAP_ONE;

  always_ff @(posedge clk) begin
    if (rst) begin
      tap_r  <= '0;
      busy_r <= 1'b0;
      psen   <= 1'b0;
      done   <= 1'b0;
    end else begin
      psen <= step.req;
      done <= 1'b0;
      if (step.req) begin
        busy_r <= 1'b1;
        tap_r  <= tap_next;
      end else if (busy_r && psdone) begin
        // A slow generator just stalls the scan.
        busy_r <= 1'b0;
        done   <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/poc_pkg.sv */
`default_nettype none

package poc_pkg;

  localparam int TAPS_PER_KCLK = 112;
  localparam int TAP_W = 7;
  localparam int SAMP_W = 8;
  localparam int SETTLE_CYCLES = 10;
  localparam int SETTLE_W = 4;
  localparam int SHORT_RUN = TAPS_PER_KCLK / 4;
  localparam int EDGE_W = 4;

  // Sized forms of the constants above.
  localparam logic [TAP_W-1:0] TAP_LAST = TAP_W'(TAPS_PER_KCLK - 1);
  localparam logic [TAP_W-1:0] TAP_ONE = TAP_W'(1);
  localparam logic [TAP_W-1:0] SHORT_RUN_LEN = TAP_W'(SHORT_RUN);
  localparam logic [SAMP_W-1:0] SAMP_ONE = SAMP_W'(1);
  localparam logic [SAMP_W:0] WIN_ONE = (SAMP_W + 1)'(1);
  localparam logic [SETTLE_W-1:0] SETTLE_LOAD = SETTLE_W'(SETTLE_CYCLES - 1);
  localparam logic [SETTLE_W-1:0] SETTLE_ONE = SETTLE_W'(1);
  localparam logic [EDGE_W-1:0] EDGE_ONE = EDGE_W'(1);

  typedef enum logic [1:0] {
    collect,   // Taking samples.
    decide,
    step,      // Shift request and run update.
    wait_done
  } scan_state_t;

endpackage

`default_nettype wire

/* hw/poc_scan_top.sv */
`timescale 1ns/1ps
`default_nettype none

module poc_scan_top (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        pd_out,
  input  wire                        sample_en,
  input  wire [poc_pkg::SAMP_W:0]    samples,
  input  wire [poc_pkg::SAMP_W:0]    solid_thresh,
  input  wire                        psdone,
  output wire                        psen,
  output wire [poc_pkg::TAP_W-1:0]   tap,
  output wire [poc_pkg::TAP_W-1:0]   run,
  output wire                        run_end,
  output wire                        run_polarity,
  output wire [poc_pkg::SAMP_W:0]    samps_hi_held,
  output wire [poc_pkg::TAP_W-1:0]   last_run,
  output wire                        run_too_small,
  output wire [poc_pkg::TAP_W-1:0]   rise_tap,
  output wire [poc_pkg::TAP_W-1:0]   fall_tap,
  output wire [poc_pkg::EDGE_W-1:0]  edges_seen
);

  wire sample_strobe;
  wire sample_value;
  wire window_done;
  wire step_done;

  step_if step_bus ();

  assign tap = step_bus.tap;

  pd_sampler u_sampler (
    .clk           (clk),
    .rst           (rst),
    .pd_out        (pd_out),
    .sample_en     (sample_en),
    .settle_start  (step_done),
    .window_done   (window_done),
    .sample_strobe (sample_strobe),
    .sample_value  (sample_value)
  );

  tap_scan u_scan (
    .clk           (clk),
    .rst           (rst),
    .samples       (samples),
    .solid_thresh  (solid_thresh),
    .sample_strobe (sample_strobe),
    .sample_value  (sample_value),
    .step          (step_bus.scanner),
    .window_done   (window_done),
    .run           (run),
    .run_end       (run_end),
    .run_polarity  (run_polarity),
    .samps_hi_held (samps_hi_held)
  );

  phase_stepper u_stepper (
    .clk    (clk),
    .rst    (rst),
    .psdone (psdone),
    .step   (step_bus.stepper),
    .psen   (psen),
    .done   (step_done)
  );

  edge_tracker u_edges (
    .clk           (clk),
    .rst           (rst),
    .run_end       (run_end),
    .run           (run),
    .run_polarity  (run_polarity),
    .tap           (step_bus.tap),
    .last_run      (last_run),
    .run_too_small (run_too_small),
    .rise_tap      (rise_tap),
    .fall_tap      (fall_tap),
    .edges_seen    (edges_seen)
  );

endmodule

`default_nettype wire

/* hw/step_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface step_if;

  logic                      req;   // One-cycle shift request.
  logic                      busy;
  logic                      done;  // Shift finished.
  logic [poc_pkg::TAP_W-1:0] tap;

  modport scanner (
    output req,
    input  busy,
    input  done
  );

  modport stepper (
    input  req,
    output busy,
    output done,
    output tap
  );

endinterface

`default_nettype wire

/* hw/tap_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module tap_scan (
  input  wire                       clk,
  input  wire                       rst,
  input  wire [poc_pkg::SAMP_W:0]   samples,
  input  wire [poc_pkg::SAMP_W:0]   solid_thresh,
  input  wire                       sample_strobe,
  input  wire                       sample_value,
  step_if.scanner                   step,
  output logic                      window_done,
  output logic [poc_pkg::TAP_W-1:0] run,
  output logic                      run_end,
  output logic                      run_polarity,
  output logic [poc_pkg::SAMP_W:0]  samps_hi_held
);

  poc_pkg::scan_state_t       state;
  logic [poc_pkg::SAMP_W-1:0] samp_cnt;
  logic [poc_pkg::SAMP_W:0]   samps_hi;
  logic [poc_pkg::SAMP_W:0]   samps_lo;
  logic                       zero_solid;
  logic                       one_solid;
  logic                       last_samp;
  logic                       fire;
  logic                       new_polarity;

  // Window holds samples plus one strobes.
  assign samps_lo = samples + poc_pkg::WIN_ONE - samps_hi;
  assign last_samp = ({1'b0, samp_cnt} == samples);
  assign window_done = (state == poc_pkg::collect) && sample_strobe && last_samp;

  assign fire = (state == poc_pkg::step) && !step.busy;
  assign step.req = fire;

  // Hysteresis. Only a solid window of the other value flips polarity.
  always_comb begin
    new_polarity = run_polarity;
    if (run_polarity && zero_solid) begin
      new_polarity = 1'b0;
    end else if (!run_polarity && one_solid) begin
      new_polarity = 1'b1;
    end
  end

  assign run_end = fire && (new_polarity != run_polarity);

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= poc_pkg::collect;
      samp_cnt      <= '0;
      samps_hi      <= '0;
      zero_solid    <= 1'b0;
      one_solid     <= 1'b0;
      run_polarity  <= 1'b0;
      run           <= '0;
      samps_hi_held <= '0;
    end else begin
      case (state)
        poc_pkg::collect: begin
          if (sample_strobe) begin
            samp_cnt <= samp_cnt + poc_pkg::SAMP_ONE;
            samps_hi <= samps_hi + {{poc_pkg::SAMP_W{1'b0}}, sample_value};
            if (last_samp) begin
              state <= poc_pkg::decide;
            end
          end
        end

        poc_pkg::decide: begin
          zero_solid <= (samps_lo >= solid_thresh);
          one_solid  <= (samps_hi >= solid_thresh);
          state      <= poc_pkg::step;
        end

        poc_pkg::step: begin
          if (fire) begin
            samps_hi_held <= samps_hi;
            samp_cnt      <= '0;
            samps_hi      <= '0;
            run_polarity  <= new_polarity;
            // Run still shows the finished length during run_end.
            if (run_end) begin
              run <= '0;
            end else begin
              run <= run + poc_pkg::TAP_ONE;
            end
            state <= poc_pkg::wait_done;
          end
        end

        poc_pkg::wait_done: begin
          if (step.done) begin
            state <= poc_pkg::collect;
          end
        end

        default: begin
          state <= poc_pkg::collect;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verif/poc_scan_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module poc_scan_assert (
  input wire clk,
  input wire rst,
  input wire psen,
  input wire psdone,
  input wire run_end
);

  logic shift_open;  // Between psen and psdone.

  always_ff @(posedge clk) begin
    if (rst) begin
      shift_open <= 1'b0;
    end else if (psen) begin
      shift_open <= 1'b1;
    end else if (psdone) begin
      shift_open <= 1'b0;
    end
  end

  psen_single: assert property (@(posedge clk) disable iff (rst) psen |=> !psen)
    else $error("psen stayed high for more than one cycle");

  psen_after_done: assert property (@(posedge clk) disable iff (rst) psen |-> !shift_open)
    else $error("second psen came before psdone");

  run_end_shift: assert property (@(posedge clk) disable iff (rst) run_end |=> psen)
    else $error("run_end was not followed by psen in the next cycle");

endmodule

bind poc_scan_top poc_scan_assert u_assert (
  .clk     (clk),
  .rst     (rst),
  .psen    (psen),
  .psdone  (psdone),
  .run_end (run_end)
);

`default_nettype wire

/* verif/tb_poc_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_poc_scan;

  localparam int PSEN_TIMEOUT = 1000;
  localparam int NUM_PHASES = 8;  // Enough edges to saturate the count.

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       pd_out;
  logic                       sample_en;
  logic [poc_pkg::SAMP_W:0]   samples;
  logic [poc_pkg::SAMP_W:0]   solid_thresh;
  logic                       psdone;
  wire                        psen;
  wire  [poc_pkg::TAP_W-1:0]  tap;
  wire  [poc_pkg::TAP_W-1:0]  run;
  wire                        run_end;
  wire                        run_polarity;
  wire  [poc_pkg::SAMP_W:0]   samps_hi_held;
  wire  [poc_pkg::TAP_W-1:0]  last_run;
  wire                        run_too_small;
  wire  [poc_pkg::TAP_W-1:0]  rise_tap;
  wire  [poc_pkg::TAP_W-1:0]  fall_tap;
  wire  [poc_pkg::EDGE_W-1:0] edges_seen;

  int seed = 32;
  int checks = 0;
  int errors = 0;
  int steps = 0;
  bit timed_out = 1'b0;
  int model_tap = 0;    // Generator tap as seen through psen.
  int model_run = 0;
  int model_edges = 0;
  bit model_pol = 1'b0;
  int hi_lo;            // High interval [hi_lo, hi_hi).
  int hi_hi;
  int win;
  int thresh;
  int noise_max;
  int noise_left;
  bit prev_run_end;
  int prev_run;

  poc_scan_top DUT (.*);

  always #4 clk = ~clk;

  task automatic expect_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("[FAIL] %0t: %s", $time, msg);
    end
  endtask

  function automatic bit tap_high(input int t);
    return (t >= hi_lo) && (t < hi_hi);
  endfunction

  // Advance to the falling edge and drive new inputs.
  task automatic next_cycle();
    bit inv;
    prev_run_end = run_end;
    prev_run = int'(run);
    @(negedge clk);
    inv = 1'b0;
    if (noise_left > 0 && ({$random(seed)} % 8) == 0) begin
      inv = 1'b1;
      noise_left--;
    end
    pd_out = tap_high(model_tap) ^ inv;
    sample_en = ({$random(seed)} % 10) < 7;  // About 70 percent.
  endtask

  task automatic set_phase(input int len, input int samp, input int thr, input int noise);
    hi_lo = 1 + int'({$random(seed)} % (poc_pkg::TAPS_PER_KCLK - 1 - len));
    hi_hi = hi_lo + len;
    win = samp + 1;
    thresh = thr;
    noise_max = noise;
    noise_left = noise;
    samples = (poc_pkg::SAMP_W + 1)'(samp);
    solid_thresh = (poc_pkg::SAMP_W + 1)'(thr);
  endtask

  // Called in the psen cycle. run_end belongs to the cycle before.
  task automatic check_step();
    bit hi;
    bit change;
    bit held_ok;
    hi = tap_high(model_tap);
    change = (hi != model_pol);
    expect_true(prev_run_end == change, $sformatf("run_end %0b at tap %0d, expected %0b",
      prev_run_end, model_tap, change));
    expect_true(run_polarity == hi, $sformatf("run_polarity %0b at tap %0d", run_polarity,
      model_tap));
    if (noise_max == 0) begin
      held_ok = int'(samps_hi_held) == (hi ? win : 0);
    end else if (hi) begin
      held_ok = int'(samps_hi_held) >= thresh;
    end else begin
      held_ok = int'(samps_hi_held) <= win - thresh;
    end
    expect_true(held_ok, $sformatf("samps_hi_held %0d at tap %0d", samps_hi_held, model_tap));
    if (change) begin
      model_edges = (model_edges < 15) ? model_edges + 1 : 15;
      expect_true(prev_run == model_run && int'(last_run) == model_run,
        $sformatf("run %0d last_run %0d, expected %0d", prev_run, last_run, model_run));
      expect_true(run_too_small == (model_run < poc_pkg::SHORT_RUN),
        $sformatf("run_too_small %0b for run %0d", run_too_small, model_run));
      expect_true(int'(hi ? rise_tap : fall_tap) == model_tap,
        $sformatf("edge tap %0d/%0d, expected %0d", rise_tap, fall_tap, model_tap));
      model_run = 0;
      model_pol = hi;
    end else begin
      model_run = (model_run + 1) % (1 << poc_pkg::TAP_W);
    end
    expect_true(int'(edges_seen) == model_edges, $sformatf("edges_seen %0d, expected %0d",
      edges_seen, model_edges));
    model_tap = (model_tap + 1) % poc_pkg::TAPS_PER_KCLK;
    expect_true(int'(tap) == model_tap, $sformatf("tap %0d, expected %0d", tap, model_tap));
    noise_left = noise_max;
    steps++;
  endtask

  task automatic do_step();
    int n;
    int d;
    n = 0;
    next_cycle();
    while (!psen && n < PSEN_TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (!psen) begin
      timed_out = 1'b1;
      $display("Timeout: no psen within %0d cycles at tap %0d", PSEN_TIMEOUT, model_tap);
    end else begin
      check_step();
      d = 1 + int'({$random(seed)} % 20);
      for (n = 0; n < d; n++) begin
        next_cycle();
        expect_true(!psen && !DUT.sample_strobe,
          $sformatf("psen or sample strobe during slow shift at tap %0d", model_tap));
      end
      psdone = 1'b1;
      next_cycle();
      psdone = 1'b0;
    end
  endtask

  task automatic check_reset_values();
    expect_true(!psen && !run_end && !run_too_small && tap == '0 && run == '0
      && edges_seen == '0, "outputs not at reset values");
  endtask

  initial begin
    int i;
    int p;
    rst = 1'b1;
    pd_out = 1'b0;
    sample_en = 1'b0;
    psdone = 1'b0;
    set_phase(10, 15, 12, 0);  // Short run.
    for (i = 0; i < 4; i++) begin
      next_cycle();
      check_reset_values();
    end
    rst = 1'b0;
    next_cycle();
    check_reset_values();
    for (p = 0; p < NUM_PHASES && !timed_out; p++) begin
      if (p == 1) begin
        set_phase(60, 15, 12, 0);
      end else if (p >= 2) begin
        set_phase(20 + int'({$random(seed)} % 61), 31, 24, 3);  // Noisy.
      end
      for (i = 0; i < poc_pkg::TAPS_PER_KCLK && !timed_out; i++) begin
        do_step();
      end
    end
    $display("Checks: %0d  errors: %0d  steps: %0d  edges: %0d  timeout: %0b",
      checks, errors, steps, model_edges, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
